//--- hdl/uart_pkg.sv
package uart_pkg;

    // Default core configuration
    localparam int DEFAULT_DATA_BITS     = 8;
    localparam int DEFAULT_OVERSAMPLE    = 16;
    localparam int DEFAULT_CLKS_PER_TICK = 16;
    localparam int DEFAULT_FIFO_DEPTH    = 16;

    // Receiver states
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    // Transmitter states
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

endpackage

//--- hdl/baud_gen.sv
`timescale 1ns/1ps

module baud_gen #(
    parameter int CLKS_PER_TICK = 16
) (
    input  logic clk,
    input  logic rst_n,
    output logic tick
);

    localparam int CNT_W = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_TICK - 1);

    logic [CNT_W-1:0] cnt;

    // Free-running divider, tick on wrap
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            if (cnt == CNT_LAST) begin
                cnt  <= '0;
                tick <= 1'b1;
            end else begin
                cnt  <= cnt + 1'b1;
                tick <= 1'b0;
            end
        end
    end

endmodule

//--- hdl/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter int DATA_WIDTH = 8,
    parameter int DEPTH      = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_en,
    input  logic [DATA_WIDTH-1:0] din,
    input  logic                  rd_en,
    output logic [DATA_WIDTH-1:0] dout,
    output logic                  empty,
    output logic                  full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;
    logic                  do_wr;
    logic                  do_rd;

    assign empty = (count == '0);
    assign full  = (count == CNT_FULL);

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // Head entry is visible without a read
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end

            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hdl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
    parameter int DATA_BITS  = 8,
    parameter int OVERSAMPLE = 16
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 tick,
    input  logic                 tx_start,
    input  logic [DATA_BITS-1:0] tx_data,
    output logic                 tx,
    output logic                 tx_busy
);

    import uart_pkg::*;

    localparam int TICK_W = $clog2(OVERSAMPLE);
    localparam int IDX_W  = $clog2(DATA_BITS);
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(OVERSAMPLE - 1);
    localparam logic [IDX_W-1:0]  IDX_LAST  = IDX_W'(DATA_BITS - 1);

    tx_state_t            state;
    logic [TICK_W-1:0]    tick_cnt;
    logic [IDX_W-1:0]     bit_idx;
    logic [DATA_BITS-1:0] shift_reg;
    logic                 load;
    logic                 bit_end;

    assign load    = (state == TX_IDLE) && tx_start && !tx_busy;
    assign bit_end = tick && (tick_cnt == TICK_LAST);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= TX_IDLE;
            tick_cnt <= '0;
            bit_idx  <= '0;
            tx       <= 1'b1;
            tx_busy  <= 1'b0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (load) begin
                        state    <= TX_START;
                        tx_busy  <= 1'b1;
                        tick_cnt <= '0;
                    end
                end

                TX_START: begin
                    // Line still high here means we have not aligned to a tick yet
                    if (tick && tx) begin
                        tx <= 1'b0;
                    end else if (bit_end) begin
                        state    <= TX_DATA;
                        tick_cnt <= '0;
                        bit_idx  <= '0;
                        tx       <= shift_reg[0];
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end

                TX_DATA: begin
                    if (bit_end) begin
                        tick_cnt <= '0;
                        if (bit_idx == IDX_LAST) begin
                            state <= TX_STOP;
                            tx    <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            tx      <= shift_reg[0];
                        end
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end

                TX_STOP: begin
                    if (bit_end) begin
                        state    <= TX_IDLE;
                        tick_cnt <= '0;
                        tx_busy  <= 1'b0;
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end

                default: state <= TX_IDLE;
            endcase
        end
    end

    // LSB leaves first
    always_ff @(posedge clk) begin
        if (load) begin
            shift_reg <= tx_data;
        end else if (bit_end && (state == TX_START || state == TX_DATA)) begin
            shift_reg <= shift_reg >> 1;
        end
    end

endmodule

//--- hdl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
    parameter int DATA_BITS  = 8,
    parameter int OVERSAMPLE = 16,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 tick,
    input  logic                 rx,
    input  logic                 rd_en,
    output logic [DATA_BITS-1:0] rx_out,
    output logic                 rx_valid,
    output logic                 fifo_empty,
    output logic                 fifo_full
);

    import uart_pkg::*;

    localparam int TICK_W = $clog2(OVERSAMPLE);
    localparam int IDX_W  = $clog2(DATA_BITS);
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(OVERSAMPLE - 1);
    localparam logic [TICK_W-1:0] TICK_HALF = TICK_W'(OVERSAMPLE / 2 - 1);
    localparam logic [IDX_W-1:0]  IDX_LAST  = IDX_W'(DATA_BITS - 1);

    rx_state_t            state;
    logic                 rx_meta;
    logic                 rx_sync;
    logic [TICK_W-1:0]    tick_cnt;
    logic [IDX_W-1:0]     bit_idx;
    logic [DATA_BITS-1:0] shift_reg;
    logic                 start_mid;
    logic                 bit_centre;
    logic                 fifo_wr_en;
    logic [DATA_BITS-1:0] fifo_dout;
    logic                 rd_ok;

    // Idle line is high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    assign start_mid  = tick && (tick_cnt == TICK_HALF);
    assign bit_centre = tick && (tick_cnt == TICK_LAST);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= RX_IDLE;
            tick_cnt   <= '0;
            bit_idx    <= '0;
            fifo_wr_en <= 1'b0;
        end else begin
            fifo_wr_en <= 1'b0;

            case (state)
                RX_IDLE: begin
                    if (tick && !rx_sync) begin
                        state    <= RX_START;
                        tick_cnt <= '0;
                    end
                end

                RX_START: begin
                    // Start bit must still be low half a bit in
                    if (start_mid) begin
                        tick_cnt <= '0;
                        bit_idx  <= '0;
                        state    <= rx_sync ? RX_IDLE : RX_DATA;
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end

                RX_DATA: begin
                    if (bit_centre) begin
                        tick_cnt <= '0;
                        if (bit_idx == IDX_LAST) begin
                            state <= RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end

                RX_STOP: begin
                    if (bit_centre) begin
                        // Low stop bit drops the frame
                        fifo_wr_en <= rx_sync;
                        tick_cnt   <= '0;
                        state      <= RX_IDLE;
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end

                default: state <= RX_IDLE;
            endcase
        end
    end

    // First bit ends up in the LSB
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_centre) begin
            shift_reg <= {rx_sync, shift_reg[DATA_BITS-1:1]};
        end
    end

    sync_fifo #(
        .DATA_WIDTH(DATA_BITS),
        .DEPTH     (FIFO_DEPTH)
    ) rx_fifo (
        .clk  (clk),
        .rst_n(rst_n),
        .wr_en(fifo_wr_en),
        .din  (shift_reg),
        .rd_en(rd_en),
        .dout (fifo_dout),
        .empty(fifo_empty),
        .full (fifo_full)
    );

    assign rd_ok = rd_en && !fifo_empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= rd_ok;
        end
    end

    // Held until the next successful read
    always_ff @(posedge clk) begin
        if (rd_ok) begin
            rx_out <= fifo_dout;
        end
    end

endmodule

//--- hdl/uart_core.sv
`timescale 1ns/1ps

module uart_core #(
    parameter int DATA_BITS     = uart_pkg::DEFAULT_DATA_BITS,
    parameter int OVERSAMPLE    = uart_pkg::DEFAULT_OVERSAMPLE,
    parameter int CLKS_PER_TICK = uart_pkg::DEFAULT_CLKS_PER_TICK,
    parameter int FIFO_DEPTH    = uart_pkg::DEFAULT_FIFO_DEPTH
) (
    input  logic                 clk,
    input  logic                 rst_n,

    // Transmit side
    input  logic                 tx_start,
    input  logic [DATA_BITS-1:0] tx_data,
    output logic                 tx_busy,
    output logic                 tx,

    // Receive side
    input  logic                 rx,
    input  logic                 rd_en,
    output logic [DATA_BITS-1:0] rx_out,
    output logic                 rx_valid,
    output logic                 fifo_empty,
    output logic                 fifo_full
);

    // One oversample tick shared by both directions
    logic tick;

    baud_gen #(
        .CLKS_PER_TICK(CLKS_PER_TICK)
    ) baud_gen_inst (
        .clk  (clk),
        .rst_n(rst_n),
        .tick (tick)
    );

    uart_tx #(
        .DATA_BITS (DATA_BITS),
        .OVERSAMPLE(OVERSAMPLE)
    ) uart_tx_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .tick    (tick),
        .tx_start(tx_start),
        .tx_data (tx_data),
        .tx      (tx),
        .tx_busy (tx_busy)
    );

    uart_rx #(
        .DATA_BITS (DATA_BITS),
        .OVERSAMPLE(OVERSAMPLE),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) uart_rx_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .tick      (tick),
        .rx        (rx),
        .rd_en     (rd_en),
        .rx_out    (rx_out),
        .rx_valid  (rx_valid),
        .fifo_empty(fifo_empty),
        .fifo_full (fifo_full)
    );

endmodule

//--- test/uart_checker.sv
`timescale 1ns/1ps

module uart_checker #(
    parameter int DATA_BITS  = 8,
    parameter int FIFO_DEPTH = 4
) (
    input logic                 clk,
    input logic                 rst_n,
    input logic [DATA_BITS-1:0] rx_out,
    input logic                 rx_valid,
    input logic                 fifo_empty,
    input logic                 fifo_full,
    input logic                 tx_busy,
    input logic                 check_flags
);

    logic [DATA_BITS-1:0] expected_q[$];
    int test_errors  = 0;
    int total_errors = 0;
    int test_reads   = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    function automatic int pending();
        return expected_q.size();
    endfunction

    task automatic push_expected(input logic [DATA_BITS-1:0] data);
        expected_q.push_back(data);
    endtask

    task automatic note_error();
        test_errors++;
        total_errors++;
    endtask

    task automatic check_tx_busy(input logic exp_busy);
        if (tx_busy !== exp_busy) begin
            $display("Fail at %0t ns: tx_busy expected %0b, got %0b",
                     $time, exp_busy, tx_busy);
            note_error();
        end
    endtask

    // Pop before the flag check so a finished read lines up with the model
    always @(posedge clk) begin : compare
        logic [DATA_BITS-1:0] exp_byte;
        if (rst_n && rx_valid) begin
            test_reads++;
            if (expected_q.size() == 0) begin
                $display("Error at %0t ns: rx_valid pulsed but no byte was expected", $time);
                note_error();
            end else begin
                exp_byte = expected_q.pop_front();
                if (rx_out !== exp_byte) begin
                    $display("Fail at %0t ns: rx_out expected 0x%h, got 0x%h",
                             $time, exp_byte, rx_out);
                    note_error();
                end
            end
        end
        if (rst_n && check_flags) begin
            if (fifo_empty !== (expected_q.size() == 0)) begin
                $display("Fail at %0t ns: fifo_empty expected %0b, got %0b",
                         $time, expected_q.size() == 0, fifo_empty);
                note_error();
            end
            if (fifo_full !== (expected_q.size() == FIFO_DEPTH)) begin
                $display("Fail at %0t ns: fifo_full expected %0b, got %0b",
                         $time, expected_q.size() == FIFO_DEPTH, fifo_full);
                note_error();
            end
        end
    end

    task automatic end_test(input string name, input int exp_reads);
        if (test_reads != exp_reads) begin
            $display("Fail at %0t ns: rx_valid count expected %0d, got %0d",
                     $time, exp_reads, test_reads);
            note_error();
        end
        if (expected_q.size() != 0) begin
            $display("Error: %0d expected bytes were never read", expected_q.size());
            note_error();
            expected_q.delete();
        end
        if (test_errors == 0) begin
            tests_passed++;
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, test_errors);
        end
        test_errors = 0;
        test_reads  = 0;
    endtask

    task automatic final_report();
        $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    endtask

endmodule

//--- test/tb_uart_core.sv
`timescale 1ns/1ps

module tb_uart_core;

    localparam int DATA_BITS      = 8;
    localparam int OVERSAMPLE     = 8;
    localparam int CLKS_PER_TICK  = 2;
    localparam int FIFO_DEPTH     = 4;
    localparam int BIT_CLKS       = OVERSAMPLE * CLKS_PER_TICK;
    localparam int NUM_FRAMES     = 20;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * 160 + 2000;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 tx_start;
    logic [DATA_BITS-1:0] tx_data;
    logic                 tx_busy;
    logic                 tx;
    logic                 rx_line;
    logic                 rx_bb;
    logic                 line_sel;
    logic                 rd_en;
    logic [DATA_BITS-1:0] rx_out;
    logic                 rx_valid;
    logic                 fifo_empty;
    logic                 fifo_full;
    logic                 check_flags;
    bit                   tx_active;
    int                   cycle_cnt = 0;
    int                   accepted;
    int                   seed_ret;

    always #20 clk = ~clk;

    // Loopback or bit-banged line
    assign rx_line = line_sel ? rx_bb : tx;

    uart_core #(
        .DATA_BITS    (DATA_BITS),
        .OVERSAMPLE   (OVERSAMPLE),
        .CLKS_PER_TICK(CLKS_PER_TICK),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) uart_core_inst (
        .clk(clk), .rst_n(rst_n), .tx_start(tx_start), .tx_data(tx_data),
        .tx_busy(tx_busy), .tx(tx), .rx(rx_line), .rd_en(rd_en), .rx_out(rx_out),
        .rx_valid(rx_valid), .fifo_empty(fifo_empty), .fifo_full(fifo_full)
    );

    uart_checker #(
        .DATA_BITS (DATA_BITS),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) uart_checker_inst (
        .clk(clk), .rst_n(rst_n), .rx_out(rx_out), .rx_valid(rx_valid),
        .fifo_empty(fifo_empty), .fifo_full(fifo_full), .tx_busy(tx_busy),
        .check_flags(check_flags)
    );

    // A byte is kept only with a good stop bit and room in the FIFO
    function automatic bit frame_queued(input bit stop_ok, input int waiting);
        return stop_ok && (waiting < FIFO_DEPTH);
    endfunction

    function automatic logic [DATA_BITS-1:0] rand_byte();
        logic [31:0] r;
        r = $urandom();
        return r[DATA_BITS-1:0];
    endfunction

    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    // Model busy flag decides which strobes count
    task automatic strobe_tx(input logic [DATA_BITS-1:0] data);
        bit take;
        take = !tx_active;
        uart_checker_inst.check_tx_busy(tx_active);
        if (take) begin
            accepted++;
            if (frame_queued(1'b1, uart_checker_inst.pending())) begin
                uart_checker_inst.push_expected(data);
            end
        end
        tx_data  = data;
        tx_start = 1'b1;
        step(1);
        tx_start = 1'b0;
        if (take) begin
            tx_active = 1'b1;
        end
        uart_checker_inst.check_tx_busy(tx_active);
    endtask

    task automatic wait_tx_done();
        while (tx_busy) step(1);
        tx_active = 1'b0;
        step(4);
        check_flags = 1'b1;
    endtask

    task automatic send_tx(input logic [DATA_BITS-1:0] data);
        check_flags = 1'b0;
        strobe_tx(data);
        wait_tx_done();
    endtask

    task automatic send_bitbang(input logic [DATA_BITS-1:0] data, input bit stop_ok);
        rx_bb = 1'b0;
        step(BIT_CLKS);
        for (int i = 0; i < DATA_BITS; i++) begin
            rx_bb = data[i];
            step(BIT_CLKS);
        end
        // No write may land before the stop bit
        check_flags = 1'b0;
        if (frame_queued(stop_ok, uart_checker_inst.pending())) begin
            uart_checker_inst.push_expected(data);
        end
        rx_bb = stop_ok;
        step(BIT_CLKS);
        rx_bb = 1'b1;
        step(BIT_CLKS);
        check_flags = 1'b1;
    endtask

    task automatic read_one();
        rd_en = 1'b1;
        step(1);
        rd_en = 1'b0;
        step(1);
    endtask

    task automatic drain_fifo();
        while (!fifo_empty) read_one();
        step(2);
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles", cycle_cnt);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        seed_ret    = $urandom(80);
        rst_n       = 1'b0;
        tx_start    = 1'b0;
        tx_data     = '0;
        rd_en       = 1'b0;
        rx_bb       = 1'b1;
        line_sel    = 1'b0;
        check_flags = 1'b0;
        tx_active   = 1'b0;
        accepted    = 0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        step(2);
        check_flags = 1'b1;

        for (int i = 0; i < 10; i++) begin
            send_tx(rand_byte());
            while (fifo_empty) step(1);
            read_one();
        end
        uart_checker_inst.end_test("loopback", 10);

        // Last two bytes find the FIFO full
        for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
            send_tx(rand_byte());
        end
        drain_fifo();
        uart_checker_inst.end_test("overflow", FIFO_DEPTH);

        line_sel = 1'b1;
        send_bitbang(rand_byte(), 1'b0);
        send_bitbang(rand_byte(), 1'b1);
        drain_fifo();
        uart_checker_inst.end_test("frame_error", 1);

        // Glitch shorter than half a bit
        rx_bb = 1'b0;
        step(3);
        rx_bb = 1'b1;
        step(BIT_CLKS);
        send_bitbang(rand_byte(), 1'b1);
        drain_fifo();
        uart_checker_inst.end_test("false_start", 1);

        line_sel = 1'b0;
        read_one();
        step(2);
        accepted    = 0;
        check_flags = 1'b0;
        strobe_tx(rand_byte());
        step(BIT_CLKS);
        strobe_tx(rand_byte());
        wait_tx_done();
        drain_fifo();
        uart_checker_inst.end_test("empty_read_busy", accepted);

        uart_checker_inst.final_report();
        if (uart_checker_inst.total_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- uart_core.f
hdl/uart_pkg.sv
hdl/baud_gen.sv
hdl/sync_fifo.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_core.sv
test/uart_checker.sv
test/tb_uart_core.sv
